//--- hw/lsu_pkg.sv
/*
  Load-store unit package
  Data and address widths, the control code encoding, the vector types
  and the load sequencer states used on the data-memory side of the core
*/
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int DATA_WIDTH     = 32;              // Data word and byte address
  localparam int REG_ADDR_WIDTH = 5;               // Register file index
  localparam int MEM_ADDR_WIDTH = 10;              // RAM word address
  localparam int RAM_DEPTH      = 2 ** MEM_ADDR_WIDTH; // 1024 words of 4 bytes
  localparam int BYTE_LANES     = DATA_WIDTH / 8;  // One enable per lane
  localparam int LSU_CTRL_WIDTH = 4;               // Store flag on top of funct3

  // Vector types
  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [LSU_CTRL_WIDTH-1:0] lsu_ctrl_t;
  typedef logic [BYTE_LANES-1:0]     byte_en_t;
  typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Control codes
  //////////////////////////////////////////////////////////////////////
  // Bit 3 selects a store, bits 2:0 are the RISC-V funct3 of the access
  localparam lsu_ctrl_t LSU_LOAD_BYTE        = 4'b0000; // LB
  localparam lsu_ctrl_t LSU_LOAD_HALF_WORD   = 4'b0001; // LH
  localparam lsu_ctrl_t LSU_LOAD_WORD        = 4'b0010; // LW
  localparam lsu_ctrl_t LSU_LOAD_BYTE_U      = 4'b0100; // LBU
  localparam lsu_ctrl_t LSU_LOAD_HALF_WORD_U = 4'b0101; // LHU

  localparam lsu_ctrl_t LSU_STORE_BYTE       = 4'b1000; // SB
  localparam lsu_ctrl_t LSU_STORE_HALF_WORD  = 4'b1001; // SH
  localparam lsu_ctrl_t LSU_STORE_WORD       = 4'b1010; // SW

  //////////////////////////////////////////////////////////////////////
  // Load sequencer
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    IDLE,       // Ready for a new request
    RAM_ADDR,   // RAM read issued
    RAM_DATA,   // RAM word on the read port
    WRITEBACK   // Extracted value to the register file
  } lsu_state_t;

endpackage

`default_nettype wire

//--- hw/lsu_store_align.sv
/*
  Store alignment
  Builds the byte enables of a store, moves the store data into the
  addressed byte lanes and flags misaligned loads and stores
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_store_align (
  input  lsu_pkg::lsu_ctrl_t ctrl_i,
  input  lsu_pkg::data_t     addr_i,
  input  lsu_pkg::data_t     wdata_i,
  output lsu_pkg::byte_en_t  byte_en_o,
  output lsu_pkg::data_t     wdata_o,
  output logic               misaligned_o
);
  import lsu_pkg::*;

  logic [1:0] byte_off;  // Byte offset inside the word
  byte_en_t   base_en;   // Enable mask before the lane shift

  assign byte_off = addr_i[1:0];

  //////////////////////////////////////////////////////////////////////
  // Width decode and lane replication
  //////////////////////////////////////////////////////////////////////
  // Byte and half-word data are copied to every lane so the shifted
  // enable mask alone picks the lanes that get written
  always_comb begin
    base_en      = '0;       // Loads and unknown codes write nothing
    wdata_o      = wdata_i;
    misaligned_o = 1'b0;
    case (ctrl_i)
      LSU_STORE_BYTE: begin
        base_en = byte_en_t'(1);                   // One lane
        wdata_o = {BYTE_LANES{wdata_i[7:0]}};
      end
      LSU_STORE_HALF_WORD: begin
        base_en      = byte_en_t'(3);              // Two lanes
        wdata_o      = {(BYTE_LANES/2){wdata_i[15:0]}};
        misaligned_o = byte_off[0];                // Odd half-word address
      end
      LSU_STORE_WORD: begin
        base_en      = '1;                         // All lanes
        misaligned_o = |byte_off;
      end
      LSU_LOAD_HALF_WORD,
      LSU_LOAD_HALF_WORD_U: begin
        misaligned_o = byte_off[0];
      end
      LSU_LOAD_WORD: begin
        misaligned_o = |byte_off;
      end
      default: begin
        base_en = '0;                              // Byte loads are always aligned
      end
    endcase
  end

  // Shift into place and drop the whole store on misalignment
  always_comb begin
    if (misaligned_o) begin
      byte_en_o = '0;
    end else begin
      byte_en_o = base_en << byte_off;
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_load_extract.sv
/*
  Load extraction
  Selects the addressed byte or half-word of a RAM word and sign- or
  zero-extends it to a full register value
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_load_extract (
  input  lsu_pkg::lsu_ctrl_t ctrl_i,
  input  logic [1:0]         byte_sel_i,
  input  lsu_pkg::data_t     word_i,
  output lsu_pkg::data_t     rdata_o
);
  import lsu_pkg::*;

  logic [7:0]  byte_lane;  // Addressed byte
  logic [15:0] half_lane;  // Addressed half-word

  //////////////////////////////////////////////////////////////////////
  // Lane select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (byte_sel_i)
      2'd0:    byte_lane = word_i[7:0];
      2'd1:    byte_lane = word_i[15:8];
      2'd2:    byte_lane = word_i[23:16];
      default: byte_lane = word_i[31:24];
    endcase
  end

  // Half-words only sit at offset 0 or 2
  always_comb begin
    if (byte_sel_i[1]) begin
      half_lane = word_i[31:16];  // Upper half
    end else begin
      half_lane = word_i[15:0];   // Lower half
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Extension
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (ctrl_i)
      LSU_LOAD_BYTE: begin
        rdata_o = {{(DATA_WIDTH-8){byte_lane[7]}}, byte_lane};    // LB
      end
      LSU_LOAD_BYTE_U: begin
        rdata_o = {{(DATA_WIDTH-8){1'b0}}, byte_lane};            // LBU
      end
      LSU_LOAD_HALF_WORD: begin
        rdata_o = {{(DATA_WIDTH-16){half_lane[15]}}, half_lane};  // LH
      end
      LSU_LOAD_HALF_WORD_U: begin
        rdata_o = {{(DATA_WIDTH-16){1'b0}}, half_lane};           // LHU
      end
      LSU_LOAD_WORD: begin
        rdata_o = word_i;                                         // LW as is
      end
      default: begin
        rdata_o = '0;  // Stores and unknown codes return nothing
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/lsu_core.sv
/*
  Load-store sequencer
  Accepts one request at a time, drives the data RAM from registers,
  walks loads through the RAM latency and hands the extended result
  to the register file writeback port
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_core (
  input  logic                clk_i,
  input  logic                rstn_i,
  // Request from execute
  input  logic                req_valid_i,
  input  lsu_pkg::lsu_ctrl_t  ctrl_i,
  input  lsu_pkg::data_t      addr_i,
  input  lsu_pkg::data_t      wdata_i,
  input  lsu_pkg::reg_addr_t  regdest_i,
  output logic                req_ready_o,
  // Register file writeback
  output lsu_pkg::data_t      rdata_o,
  output logic                rf_wb_o,
  output lsu_pkg::reg_addr_t  regdest_o,
  output logic                misaligned_o,
  // Data RAM
  output logic                ram_en_o,
  output lsu_pkg::byte_en_t   ram_we_o,
  output lsu_pkg::mem_addr_t  ram_addr_o,
  output lsu_pkg::data_t      ram_wdata_o,
  input  lsu_pkg::data_t      ram_rdata_i
);
  import lsu_pkg::*;

  lsu_state_t state_q;
  logic       is_store;       // Top bit of the control code
  logic       accept;         // Handshake this cycle
  logic       load_accept;    // Aligned load taken
  byte_en_t   st_byte_en;
  data_t      st_wdata;
  logic       st_misaligned;
  lsu_ctrl_t  ctrl_q;         // Load code kept for extraction
  logic [1:0] byte_sel_q;     // Load byte offset
  data_t      data_q;         // Captured RAM word

  assign is_store    = ctrl_i[LSU_CTRL_WIDTH-1];
  assign req_ready_o = (state_q == IDLE);  // Low for the whole load
  assign accept      = req_valid_i & req_ready_o;
  assign load_accept = accept & ~is_store & ~st_misaligned;

  lsu_store_align u_store_align (
    .ctrl_i       (ctrl_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .byte_en_o    (st_byte_en),
    .wdata_o      (st_wdata),
    .misaligned_o (st_misaligned)
  );

  //////////////////////////////////////////////////////////////////////
  // RAM command registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      ram_en_o     <= 1'b0;
      ram_we_o     <= '0;
      misaligned_o <= 1'b0;
    end else begin
      ram_en_o     <= load_accept | (accept & |st_byte_en); // Read or real write
      ram_we_o     <= accept ? st_byte_en : '0;             // Zero when misaligned
      misaligned_o <= accept & st_misaligned;               // One-cycle error pulse
    end
  end

  // Address and write data only matter while ram_en_o is set
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ram_addr_o  <= addr_i[MEM_ADDR_WIDTH+1:2];  // Word address
      ram_wdata_o <= st_wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Load sequencer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:      if (load_accept) state_q <= RAM_ADDR;
        RAM_ADDR:  state_q <= RAM_DATA;   // RAM registers the word
        RAM_DATA:  state_q <= WRITEBACK;  // Word into data_q
        WRITEBACK: state_q <= IDLE;
        default:   state_q <= IDLE;
      endcase
    end
  end

  // Load context
  always_ff @(posedge clk_i) begin
    if (load_accept) begin
      ctrl_q     <= ctrl_i;
      byte_sel_q <= addr_i[1:0];
      regdest_o  <= regdest_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == RAM_DATA) begin
      data_q <= ram_rdata_i;  // Read port is valid here
    end
  end

  assign rf_wb_o = (state_q == WRITEBACK);

  lsu_load_extract u_load_extract (
    .ctrl_i     (ctrl_q),
    .byte_sel_i (byte_sel_q),
    .word_i     (data_q),
    .rdata_o    (rdata_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////
  a_wb_not_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(rf_wb_o && req_ready_o));

  // A rejected access must never reach the RAM
  a_misaligned_no_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
    misaligned_o |-> (ram_we_o == '0));

  a_load_returns: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (state_q != IDLE) |-> ##[1:3] (state_q == IDLE));

endmodule

`default_nettype wire

//--- hw/data_ram.sv
/*
  Data RAM
  Single-port word memory with byte write enables, one-cycle registered
  read and read data held steady during writes
*/
`timescale 1ns/10ps
`default_nettype none

module data_ram (
  input  logic               clk_i,
  input  logic               en_i,
  input  lsu_pkg::byte_en_t  we_i,
  input  lsu_pkg::mem_addr_t addr_i,
  input  lsu_pkg::data_t     wdata_i,
  output lsu_pkg::data_t     rdata_o
);
  import lsu_pkg::*;

  data_t mem [RAM_DEPTH];  // Contents undefined after power-up

  //////////////////////////////////////////////////////////////////////
  // Byte write port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      for (int i = 0; i < BYTE_LANES; i++) begin
        if (we_i[i]) begin
          mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];  // Lane i only
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////
  // No-change mode. The output register only loads on a pure read,
  // so a write cycle keeps the last read word on rdata_o
  always_ff @(posedge clk_i) begin
    if (en_i && (we_i == '0)) begin
      rdata_o <= mem[addr_i];
    end
  end

  // Writes are only meaningful with the port enabled
  a_we_needs_en: assert property (@(posedge clk_i)
    (we_i != '0) |-> en_i);

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
/*
  Load-store subsystem
  Load-store sequencer wired to its private data RAM
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
  input  logic               clk_i,
  input  logic               rstn_i,
  // Request
  input  logic               req_valid_i,
  input  lsu_pkg::lsu_ctrl_t ctrl_i,
  input  lsu_pkg::data_t     addr_i,
  input  lsu_pkg::data_t     wdata_i,
  input  lsu_pkg::reg_addr_t regdest_i,
  output logic               req_ready_o,
  // Writeback
  output lsu_pkg::data_t     rdata_o,
  output logic               rf_wb_o,
  output lsu_pkg::reg_addr_t regdest_o,
  output logic               misaligned_o
);
  import lsu_pkg::*;

  // RAM port
  logic      ram_en;
  byte_en_t  ram_we;
  mem_addr_t ram_addr;
  data_t     ram_wdata;
  data_t     ram_rdata;

  lsu_core u_lsu_core (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .req_valid_i  (req_valid_i),
    .ctrl_i       (ctrl_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .regdest_i    (regdest_i),
    .req_ready_o  (req_ready_o),
    .rdata_o      (rdata_o),
    .rf_wb_o      (rf_wb_o),
    .regdest_o    (regdest_o),
    .misaligned_o (misaligned_o),
    .ram_en_o     (ram_en),
    .ram_we_o     (ram_we),
    .ram_addr_o   (ram_addr),
    .ram_wdata_o  (ram_wdata),
    .ram_rdata_i  (ram_rdata)
  );

  data_ram u_data_ram (
    .clk_i   (clk_i),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)  // Registered inside the RAM
  );

endmodule

`default_nettype wire

//--- verification/lsu_tb.sv
/*
  Load-store subsystem testbench
  Issues requests, keeps a byte image of the RAM and checks writebacks,
  latency, handshake and misalignment with concurrent assertions
*/
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;
  import lsu_pkg::*;

  localparam int    CLK_PERIOD = 100;
  localparam int    RAND_OPS   = 200;
  localparam int    NUM_REQ    = 10 + 12 + 11 + 7 + 14 + 16 + RAND_OPS;
  localparam int    WD_CYCLES  = NUM_REQ * 4 + 100;  // Four cycles per request plus margin
  localparam data_t WIN_BASE   = 32'h0000_0200;      // Random window of 64 bytes

  logic      clk = 1'b0;
  logic      rstn;
  logic      req_valid;
  lsu_ctrl_t req_ctrl;
  data_t     req_addr;
  data_t     req_wdata;
  reg_addr_t req_regdest;
  logic      req_ready;
  data_t     wb_rdata;
  logic      rf_wb;
  reg_addr_t wb_regdest;
  logic      misaligned;

  logic [7:0]  ref_mem [2 ** (MEM_ADDR_WIDTH + 2)];  // Byte image of the RAM
  logic [68:0] exp_q [$];        // {writeback cycle, regdest, data} per load
  data_t       exp_data;
  reg_addr_t   exp_rd;
  int          exp_cyc;
  logic        exp_pend = 1'b0;  // Load in flight
  int          cyc = 0;          // Rising edges so far
  int          mis_cyc = -1;     // Cycle of the expected error pulse
  int          last_acc;         // Accept edge of the latest request
  logic [31:0] rng = 32'h272fcfe7;
  string       test_name = "reset";
  int          errors = 0;
  int          err_start;
  int          n_tests = 0;
  int          n_failed = 0;

  lsu_top u_dut (
    .clk_i        (clk),
    .rstn_i       (rstn),
    .req_valid_i  (req_valid),
    .ctrl_i       (req_ctrl),
    .addr_i       (req_addr),
    .wdata_i      (req_wdata),
    .regdest_i    (req_regdest),
    .req_ready_o  (req_ready),
    .rdata_o      (wb_rdata),
    .rf_wb_o      (rf_wb),
    .regdest_o    (wb_regdest),
    .misaligned_o (misaligned)
  );

  always #(CLK_PERIOD/2) clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // Queue head tracks the load in flight and retires after its writeback cycle
  always @(posedge clk) begin
    #2;
    if (exp_pend && cyc > exp_cyc) exp_pend = 1'b0;
    if (!exp_pend && exp_q.size() > 0) begin
      {exp_cyc, exp_rd, exp_data} = exp_q.pop_front();
      exp_pend = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks sampled mid-cycle
  //////////////////////////////////////////////////////////////////////
  a_wb_data: assert property (@(negedge clk) disable iff (!rstn)
    rf_wb |-> wb_rdata == exp_data)
  else begin
    $display("ERR %s: rdata expected %h, actual %h", test_name, exp_data, wb_rdata);
    errors++;
  end

  a_wb_rd: assert property (@(negedge clk) disable iff (!rstn)
    rf_wb |-> wb_regdest == exp_rd)
  else begin
    $display("ERR %s: regdest expected %0d, actual %0d", test_name, exp_rd, wb_regdest);
    errors++;
  end

  // Writeback only two edges after an accepted aligned load
  a_wb_cycle: assert property (@(negedge clk) disable iff (!rstn)
    rf_wb == (exp_pend && cyc == exp_cyc))
  else begin
    $display("ERR %s: rf_wb expected %b, actual %b", test_name,
             (exp_pend && cyc == exp_cyc), rf_wb);
    errors++;
  end

  a_ready: assert property (@(negedge clk) disable iff (!rstn)
    req_ready == !exp_pend)
  else begin
    $display("ERR %s: req_ready expected %b, actual %b", test_name, !exp_pend, req_ready);
    errors++;
  end

  a_mis: assert property (@(negedge clk) disable iff (!rstn)
    misaligned == (cyc == mis_cyc))
  else begin
    $display("ERR %s: misaligned expected %b, actual %b", test_name,
             (cyc == mis_cyc), misaligned);
    errors++;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic is_misaligned(input lsu_ctrl_t op, input data_t a);
    case (op[1:0])
      2'b01:   return a[0];      // Half-word on an odd address
      2'b10:   return |a[1:0];   // Word off a four-byte boundary
      default: return 1'b0;
    endcase
  endfunction

  function automatic void store_ref(input lsu_ctrl_t op, input data_t a, input data_t d);
    int n;
    n = (op[1:0] == 2'b00) ? 1 : (op[1:0] == 2'b01) ? 2 : 4;
    for (int i = 0; i < n; i++) ref_mem[a[11:0] + 12'(i)] = d[8*i +: 8];  // Little endian
  endfunction

  function automatic data_t load_value(input lsu_ctrl_t op, input data_t a);
    data_t w;
    w = {ref_mem[a[11:0] + 12'd3], ref_mem[a[11:0] + 12'd2],
         ref_mem[a[11:0] + 12'd1], ref_mem[a[11:0]]};  // Bytes from the load address up
    case (op)
      LSU_LOAD_BYTE:        return {{24{w[7]}}, w[7:0]};
      LSU_LOAD_BYTE_U:      return {24'd0, w[7:0]};
      LSU_LOAD_HALF_WORD:   return {{16{w[15]}}, w[15:0]};
      LSU_LOAD_HALF_WORD_U: return {16'd0, w[15:0]};
      default:              return w;
    endcase
  endfunction

  function automatic lsu_ctrl_t pick_code(input logic [2:0] sel);
    case (sel)
      3'd0: return LSU_LOAD_BYTE;
      3'd1: return LSU_LOAD_HALF_WORD;
      3'd2: return LSU_LOAD_WORD;
      3'd3: return LSU_LOAD_BYTE_U;
      3'd4: return LSU_LOAD_HALF_WORD_U;
      3'd5: return LSU_STORE_BYTE;
      3'd6: return LSU_STORE_HALF_WORD;
      default: return LSU_STORE_WORD;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  // Holds the request until req_ready is seen before an edge
  task automatic issue(input lsu_ctrl_t op, input data_t a, input data_t d, input reg_addr_t rd);
    logic rdy;
    int   tries;
    rdy = 1'b0;
    tries = 0;
    req_valid = 1'b1;
    req_ctrl = op;
    req_addr = a;
    req_wdata = d;
    req_regdest = rd;
    while (!rdy && tries < 10) begin
      @(negedge clk);
      rdy = req_ready;
      @(posedge clk);
      #1;
      tries++;
    end
    req_valid = 1'b0;
    if (!rdy) begin
      $display("%s: request was never accepted", test_name);
      errors++;
    end else begin
      last_acc = cyc;
      if (is_misaligned(op, a)) mis_cyc = cyc;
      else if (op[3]) store_ref(op, a, d);
      else exp_q.push_back({cyc + 2, rd, load_value(op, a)});
    end
  endtask

  task automatic start_case(input string name);
    test_name = name;
    err_start = errors;
    n_tests++;
  endtask

  // Waits for the last writeback and prints one line for the test
  task automatic report_case;
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while ((exp_pend || exp_q.size() != 0) && n < 10);
    if (n >= 10) begin
      $display("%s: load writeback never arrived", test_name);
      errors++;
    end
    @(posedge clk);
    #1;
    if (errors == err_start) $display("%-18s ok", test_name);
    else begin
      $display("%-18s FAILED with %0d errors", test_name, errors - err_start);
      n_failed++;
    end
  endtask

  task automatic word_roundtrip;
    data_t addrs [4];
    addrs = '{32'h000, 32'h004, 32'h3f8, 32'hffc};  // Includes the last word
    start_case("word_roundtrip");
    foreach (addrs[i]) begin
      rng = xorshift(rng);
      issue(LSU_STORE_WORD, addrs[i], rng, '0);
    end
    foreach (addrs[i]) issue(LSU_LOAD_WORD, addrs[i], '0, reg_addr_t'(i + 1));
    issue(LSU_STORE_WORD, 32'h000, 32'h5a5a_0ff0, '0);
    issue(LSU_LOAD_WORD, 32'h000, '0, 5'd31);
    report_case();
  endtask

  task automatic byte_lanes;
    logic [7:0] vals [4];
    vals = '{8'h81, 8'h7f, 8'hc3, 8'h24};
    start_case("byte_lanes");
    for (int i = 0; i < 4; i++) issue(LSU_STORE_BYTE, 32'h040 + i, {24'ha5a5a5, vals[i]}, '0);
    for (int i = 0; i < 4; i++) begin
      issue(LSU_LOAD_BYTE, 32'h040 + i, '0, reg_addr_t'(i + 8));
      issue(LSU_LOAD_BYTE_U, 32'h040 + i, '0, reg_addr_t'(i + 12));
    end
    report_case();
  endtask

  task automatic half_words;
    start_case("half_words");
    issue(LSU_STORE_WORD, 32'h080, 32'h1234_5678, '0);
    issue(LSU_STORE_HALF_WORD, 32'h080, 32'hdead_8001, '0);  // Top bit set
    issue(LSU_STORE_HALF_WORD, 32'h082, 32'hbeef_7ffe, '0);  // Top bit clear
    for (int i = 0; i < 4; i += 2) begin
      issue(LSU_LOAD_HALF_WORD, 32'h080 + i, '0, reg_addr_t'(i + 3));
      issue(LSU_LOAD_HALF_WORD_U, 32'h080 + i, '0, reg_addr_t'(i + 4));
    end
    issue(LSU_STORE_HALF_WORD, 32'h082, 32'h0000_c3a5, '0);
    issue(LSU_LOAD_HALF_WORD, 32'h082, '0, 5'd9);
    issue(LSU_LOAD_HALF_WORD_U, 32'h082, '0, 5'd10);
    issue(LSU_LOAD_HALF_WORD, 32'h080, '0, 5'd11);  // Lower half intact
    report_case();
  endtask

  task automatic load_latency;
    int load_acc;
    int prev;
    start_case("load_latency");
    issue(LSU_STORE_WORD, 32'h0c0, 32'h0bad_cafe, '0);
    issue(LSU_LOAD_WORD, 32'h0c0, '0, 5'd17);
    load_acc = last_acc;
    prev = last_acc;
    for (int i = 0; i < 4; i++) begin
      rng = xorshift(rng);
      issue(LSU_STORE_WORD, 32'h0c4 + 4 * i, rng, '0);
      // Ready returns with IDLE at edge 3 and stores then go every edge
      assert (last_acc == prev + ((i == 0) ? 4 : 1)) else begin
        $display("ERR %s: accept edge expected %0d, actual %0d", test_name,
                 prev + ((i == 0) ? 4 : 1) - load_acc, last_acc - load_acc);
        errors++;
      end
      prev = last_acc;
    end
    issue(LSU_LOAD_WORD, 32'h0d0, '0, 5'd18);
    report_case();
  endtask

  task automatic misaligned_access;
    start_case("misaligned_access");
    issue(LSU_STORE_WORD, 32'h100, 32'hcafe_f00d, '0);
    for (int i = 1; i < 4; i++) begin
      issue(LSU_LOAD_WORD, 32'h100 + i, '0, 5'd7);
      issue(LSU_STORE_WORD, 32'h100 + i, 32'hffff_ffff, '0);
    end
    for (int i = 1; i < 4; i += 2) begin
      issue(LSU_LOAD_HALF_WORD, 32'h100 + i, '0, 5'd8);
      issue(LSU_LOAD_HALF_WORD_U, 32'h100 + i, '0, 5'd9);
      issue(LSU_STORE_HALF_WORD, 32'h100 + i, 32'hffff_ffff, '0);
    end
    issue(LSU_LOAD_WORD, 32'h100, '0, 5'd10);  // Word must be untouched
    report_case();
  endtask

  task automatic random_mix;
    lsu_ctrl_t op;
    data_t     a;
    reg_addr_t rd;
    start_case("random_mix");
    for (int i = 0; i < 16; i++) begin  // Define every byte of the window
      rng = xorshift(rng);
      issue(LSU_STORE_WORD, WIN_BASE + 4 * i, rng, '0);
    end
    for (int i = 0; i < RAND_OPS; i++) begin
      rng = xorshift(rng);
      op = pick_code(rng[2:0]);
      a = WIN_BASE + {26'd0, rng[13:8]};
      if (op[1:0] == 2'b01) a[0] = 1'b0;
      else if (op[1:0] == 2'b10) a[1:0] = 2'b00;
      rd = rng[20:16];
      rng = xorshift(rng);
      issue(op, a, rng, rd);
    end
    report_case();
  endtask

  initial begin
    rstn = 1'b0;
    req_valid = 1'b0;
    req_ctrl = '0;
    req_addr = '0;
    req_wdata = '0;
    req_regdest = '0;
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    word_roundtrip();
    byte_lanes();
    half_words();
    load_latency();
    misaligned_access();
    random_mix();
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             n_tests, n_tests - n_failed, n_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles in %s", WD_CYCLES, test_name);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_extract.sv
hw/lsu_core.sv
hw/data_ram.sv
hw/lsu_top.sv
verification/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module lsu_tb -f files.f

./obj_dir/Vlsu_tb | tee sim.log

if grep -qx "Verification passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
